// File: core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam logic [XLEN-1:0] RESET_PC = 32'h3000_0000;
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU
  } branch_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,
    WB_NONE
  } wb_sel_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_t               alu_op;
    branch_t               branch;
    wb_sel_t               wb_sel;
    logic                  use_imm;
    logic                  use_pc;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_halt;
  } decoded_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
    logic                  we;
    logic [XLEN-1:0]       next_pc;
    logic                  is_halt;
  } exec_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       data;
    logic                  we;
  } retire_t;

endpackage

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic                           clock_i,
  input  wire logic                           reset_i,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic      [core_pkg::XLEN-1:0]       rs1_data_o,
  output logic      [core_pkg::XLEN-1:0]       rs2_data_o,
  input  wire logic                           we_i,
  input  wire logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  wire logic [core_pkg::XLEN-1:0]       wdata_i
);

  logic [core_pkg::XLEN-1:0] regs [2**core_pkg::REG_ADDR_W];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**core_pkg::REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      // x0 never gets written
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_addr_i];
  assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

// File: decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  wire logic                            clock_i,
  input  wire logic                            reset_i,
  input  wire logic                            fetch_valid_i,
  input  wire logic [core_pkg::XLEN-1:0]       pc_i,
  input  wire logic [31:0]                     instr_i,
  output logic      [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic      [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  input  wire logic [core_pkg::XLEN-1:0]       rs1_data_i,
  input  wire logic [core_pkg::XLEN-1:0]       rs2_data_i,
  output logic                                 dec_valid_o,
  output core_pkg::decoded_t                   dec_o
);

  core_pkg::opcode_t            opcode;
  logic [2:0]                   funct3;
  logic                         funct7_b5;
  logic [core_pkg::XLEN-1:0]    imm_i;
  logic [core_pkg::XLEN-1:0]    imm_u;
  logic [core_pkg::XLEN-1:0]    imm_j;
  logic [core_pkg::XLEN-1:0]    imm_b;
  core_pkg::decoded_t           dec_d;

  // funct7 bit 5 selects sub only for register ops
  function automatic core_pkg::alu_op_t alu_from_funct(input logic [2:0] f3,
                                                      input logic f7_b5,
                                                      input logic is_reg);
    core_pkg::alu_op_t op;
    case (f3)
      3'b000: op = (is_reg && f7_b5) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001: op = core_pkg::ALU_SLL;
      3'b010: op = core_pkg::ALU_SLT;
      3'b011: op = core_pkg::ALU_SLTU;
      3'b100: op = core_pkg::ALU_XOR;
      3'b101: op = f7_b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110: op = core_pkg::ALU_OR;
      default: op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode    = core_pkg::opcode_t'(instr_i[6:0]);
  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];

  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  always_comb begin
    dec_d         = '0;
    dec_d.pc      = pc_i;
    dec_d.rs1_val = rs1_data_i;
    dec_d.rs2_val = rs2_data_i;
    dec_d.rd      = instr_i[11:7];
    dec_d.alu_op  = core_pkg::ALU_ADD;
    dec_d.branch  = core_pkg::BR_NONE;
    dec_d.wb_sel  = core_pkg::WB_NONE;
    case (opcode)
      core_pkg::OP: begin
        dec_d.alu_op = alu_from_funct(funct3, funct7_b5, 1'b1);
        dec_d.wb_sel = core_pkg::WB_ALU;
      end
      core_pkg::OP_IMM: begin
        dec_d.alu_op  = alu_from_funct(funct3, funct7_b5, 1'b0);
        dec_d.imm     = imm_i;
        dec_d.use_imm = 1'b1;
        dec_d.wb_sel  = core_pkg::WB_ALU;
      end
      core_pkg::LUI: begin
        dec_d.alu_op  = core_pkg::ALU_PASS_B;
        dec_d.imm     = imm_u;
        dec_d.use_imm = 1'b1;
        dec_d.wb_sel  = core_pkg::WB_ALU;
      end
      core_pkg::AUIPC: begin
        dec_d.imm     = imm_u;
        dec_d.use_imm = 1'b1;
        dec_d.use_pc  = 1'b1;
        dec_d.wb_sel  = core_pkg::WB_ALU;
      end
      core_pkg::JAL: begin
        dec_d.imm    = imm_j;
        dec_d.is_jal = 1'b1;
        dec_d.wb_sel = core_pkg::WB_LINK;
      end
      core_pkg::JALR: begin
        // alu adds rs1 and imm for the target
        dec_d.imm     = imm_i;
        dec_d.use_imm = 1'b1;
        dec_d.is_jalr = 1'b1;
        dec_d.wb_sel  = core_pkg::WB_LINK;
      end
      core_pkg::BRANCH: begin
        dec_d.imm = imm_b;
        case (funct3)
          3'b000:  dec_d.branch = core_pkg::BEQ;
          3'b001:  dec_d.branch = core_pkg::BNE;
          3'b100:  dec_d.branch = core_pkg::BLT;
          3'b101:  dec_d.branch = core_pkg::BGE;
          3'b110:  dec_d.branch = core_pkg::BLTU;
          3'b111:  dec_d.branch = core_pkg::BGEU;
          default: dec_d.branch = core_pkg::BR_NONE;
        endcase
      end
      core_pkg::SYSTEM: begin
        dec_d.is_halt = (instr_i == core_pkg::EBREAK_INSTR);
      end
      default: begin
        // unsupported opcodes retire with no write
        dec_d.wb_sel = core_pkg::WB_NONE;
      end
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= fetch_valid_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (fetch_valid_i) begin
      dec_o <= dec_d;
    end
  end

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire logic                clock_i,
  input  wire logic                reset_i,
  input  wire logic                dec_valid_i,
  input  wire core_pkg::decoded_t  dec_i,
  output logic                     exe_valid_o,
  output core_pkg::exec_t          exe_o
);

  logic [core_pkg::XLEN-1:0] op_a;
  logic [core_pkg::XLEN-1:0] op_b;
  logic [core_pkg::XLEN-1:0] alu_res;
  logic [core_pkg::XLEN-1:0] pc_plus4;
  logic [core_pkg::XLEN-1:0] pc_target;
  logic                      taken;
  core_pkg::exec_t           exe_d;

  assign op_a = dec_i.use_pc ? dec_i.pc : dec_i.rs1_val;
  assign op_b = dec_i.use_imm ? dec_i.imm : dec_i.rs2_val;

  always_comb begin
    case (dec_i.alu_op)
      core_pkg::ALU_ADD:    alu_res = op_a + op_b;
      core_pkg::ALU_SUB:    alu_res = op_a - op_b;
      core_pkg::ALU_AND:    alu_res = op_a & op_b;
      core_pkg::ALU_OR:     alu_res = op_a | op_b;
      core_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
      core_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
      core_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
      core_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
      core_pkg::ALU_PASS_B: alu_res = op_b;
      default:              alu_res = '0;
    endcase
  end

  // branch compare always uses both register values
  always_comb begin
    case (dec_i.branch)
      core_pkg::BEQ:  taken = dec_i.rs1_val == dec_i.rs2_val;
      core_pkg::BNE:  taken = dec_i.rs1_val != dec_i.rs2_val;
      core_pkg::BLT:  taken = $signed(dec_i.rs1_val) < $signed(dec_i.rs2_val);
      core_pkg::BGE:  taken = $signed(dec_i.rs1_val) >= $signed(dec_i.rs2_val);
      core_pkg::BLTU: taken = dec_i.rs1_val < dec_i.rs2_val;
      core_pkg::BGEU: taken = dec_i.rs1_val >= dec_i.rs2_val;
      default:        taken = 1'b0;
    endcase
  end

  assign pc_plus4  = dec_i.pc + 32'd4;
  assign pc_target = dec_i.pc + dec_i.imm;

  always_comb begin
    exe_d.pc      = dec_i.pc;
    exe_d.rd      = dec_i.rd;
    exe_d.is_halt = dec_i.is_halt;
    exe_d.we      = dec_i.wb_sel != core_pkg::WB_NONE;
    exe_d.result  = (dec_i.wb_sel == core_pkg::WB_LINK) ? pc_plus4 : alu_res;
    if (dec_i.is_jal || taken) begin
      exe_d.next_pc = pc_target;
    end else if (dec_i.is_jalr) begin
      exe_d.next_pc = {alu_res[core_pkg::XLEN-1:1], 1'b0};
    end else begin
      exe_d.next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      exe_valid_o <= 1'b0;
    end else begin
      exe_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (dec_valid_i) begin
      exe_o <= exe_d;
    end
  end

endmodule

`default_nettype wire

// File: result_unit.sv
`timescale 1ns/1ps
`default_nettype none

module result_unit (
  input  wire logic                            clock_i,
  input  wire logic                            reset_i,
  input  wire logic                            exe_valid_i,
  input  wire core_pkg::exec_t                 exe_i,
  output logic      [core_pkg::XLEN-1:0]       pc_o,
  output logic                                 fetch_valid_o,
  output logic                                 we_o,
  output logic      [core_pkg::REG_ADDR_W-1:0] waddr_o,
  output logic      [core_pkg::XLEN-1:0]       wdata_o,
  output logic                                 retire_valid_o,
  output core_pkg::retire_t                    retire_o,
  output logic                                 halted_o
);

  logic commit;

  assign commit = exe_valid_i && !exe_i.is_halt;

  // register write lands on the same edge the pc moves
  assign we_o    = commit && exe_i.we;
  assign waddr_o = exe_i.rd;
  assign wdata_o = exe_i.result;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      pc_o           <= core_pkg::RESET_PC;
      fetch_valid_o  <= 1'b1;
      retire_valid_o <= 1'b0;
      halted_o       <= 1'b0;
    end else begin
      fetch_valid_o  <= commit;
      retire_valid_o <= commit;
      if (commit) begin
        pc_o <= exe_i.next_pc;
      end
      if (exe_valid_i && exe_i.is_halt) begin
        halted_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (commit) begin
      retire_o.pc   <= exe_i.pc;
      retire_o.rd   <= exe_i.rd;
      retire_o.data <= exe_i.result;
      retire_o.we   <= exe_i.we;
    end
  end

endmodule

`default_nettype wire

// File: core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  wire logic                      clock_i,
  input  wire logic                      reset_i,
  output logic      [core_pkg::XLEN-1:0] imem_addr_o,
  input  wire logic [31:0]               imem_data_i,
  output logic                           retire_valid_o,
  output core_pkg::retire_t              retire_o,
  output logic                           halted_o
);

  logic                            fetch_valid;
  logic [core_pkg::XLEN-1:0]       pc;
  logic                            dec_valid;
  core_pkg::decoded_t              dec;
  logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [core_pkg::XLEN-1:0]       rs1_data;
  logic [core_pkg::XLEN-1:0]       rs2_data;
  logic                            exe_valid;
  core_pkg::exec_t                 exe;
  logic                            rf_we;
  logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [core_pkg::XLEN-1:0]       rf_wdata;

  assign imem_addr_o = pc;

  reg_file u_reg_file (
    .clock_i    (clock_i),
    .reset_i    (reset_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

  decode_unit u_decode (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .fetch_valid_i (fetch_valid),
    .pc_i          (pc),
    .instr_i       (imem_data_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec)
  );

  execute_unit u_execute (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .exe_valid_o (exe_valid),
    .exe_o       (exe)
  );

  result_unit u_result (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .exe_valid_i    (exe_valid),
    .exe_i          (exe),
    .pc_o           (pc),
    .fetch_valid_o  (fetch_valid),
    .we_o           (rf_we),
    .waddr_o        (rf_waddr),
    .wdata_o        (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .halted_o       (halted_o)
  );

endmodule

`default_nettype wire

// File: tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int N_EXP       = 26;
  localparam int ROM_WORDS   = 32;
  localparam int WATCHDOG_NS = (N_EXP + 4) * 3 * 10 * 4;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        we;
    logic [31:0] data;
  } expect_t;

  logic               clock;
  logic               reset;
  logic [31:0]        imem_addr;
  logic [31:0]        imem_data;
  logic               retire_valid;
  core_pkg::retire_t  retire;
  logic               halted;

  logic [31:0] rom [ROM_WORDS];
  logic [31:0] rom_idx;
  expect_t     exp_tab [N_EXP];
  string       exp_name [N_EXP];
  int          n_added;
  int          n_seen;
  int          n_pass;
  int          n_fail;

  core_top dut (
    .clock_i        (clock),
    .reset_i        (reset),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .halted_o       (halted)
  );

  // combinational instruction port with ebreak outside the program
  assign rom_idx   = (imem_addr - core_pkg::RESET_PC) >> 2;
  assign imem_data = (rom_idx < ROM_WORDS) ? rom[rom_idx[4:0]] : core_pkg::EBREAK_INSTR;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] addr_of(input int idx);
    return core_pkg::RESET_PC + idx * 4;
  endfunction

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'(core_pkg::OP)};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] u_type(input int imm20, input int rd, input logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'(core_pkg::JAL)};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            7'(core_pkg::BRANCH)};
  endfunction

  task automatic add_expect(input string name, input int idx, input int rd,
                            input logic we, input logic [31:0] data);
    exp_name[n_added]     = name;
    exp_tab[n_added].pc   = addr_of(idx);
    exp_tab[n_added].rd   = rd[4:0];
    exp_tab[n_added].we   = we;
    exp_tab[n_added].data = data;
    n_added++;
  endtask

  task automatic compare(input string test, input string field, input logic [31:0] expected,
                         input logic [31:0] actual, inout logic ok);
    assert (actual == expected) else begin
      $display("ERROR %s %s: expected %h, actual %h", test, field, expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string test, input logic ok);
    if (ok) begin
      $display("ok    %s", test);
      n_pass++;
    end else begin
      $display("fail  %s", test);
      n_fail++;
    end
  endtask

  task automatic check_retire(input int idx);
    expect_t e;
    logic    ok;
    e  = exp_tab[idx];
    ok = 1'b1;
    compare(exp_name[idx], "pc", e.pc, retire.pc, ok);
    compare(exp_name[idx], "rd", {27'b0, e.rd}, {27'b0, retire.rd}, ok);
    compare(exp_name[idx], "we", {31'b0, e.we}, {31'b0, retire.we}, ok);
    if (e.we) begin
      compare(exp_name[idx], "data", e.data, retire.data, ok);
    end
    report_test(exp_name[idx], ok);
  endtask

  initial begin
    // x1 = 100, x2 = -7, x10 = shift amount
    rom[0]  = i_type(100, 0, 0, 1, core_pkg::OP_IMM);
    rom[1]  = i_type(-7, 0, 0, 2, core_pkg::OP_IMM);
    rom[2]  = r_type(0, 2, 1, 0, 3);
    rom[3]  = r_type(32, 2, 1, 0, 4);
    rom[4]  = r_type(0, 2, 1, 7, 5);
    rom[5]  = r_type(0, 2, 1, 6, 6);
    rom[6]  = r_type(0, 2, 1, 4, 7);
    rom[7]  = r_type(0, 1, 2, 2, 8);
    rom[8]  = r_type(0, 1, 2, 3, 9);
    rom[9]  = i_type(3, 0, 0, 10, core_pkg::OP_IMM);
    rom[10] = r_type(0, 10, 2, 1, 11);
    rom[11] = r_type(0, 10, 2, 5, 12);
    rom[12] = r_type(32, 10, 2, 5, 13);
    rom[13] = i_type(55, 0, 0, 0, core_pkg::OP_IMM);
    rom[14] = r_type(0, 1, 0, 0, 14);
    rom[15] = u_type(32'h12345, 15, core_pkg::LUI);
    rom[16] = u_type(1, 16, core_pkg::AUIPC);
    // taken branches skip one slot each
    rom[17] = b_type(8, 1, 1, 0);
    rom[18] = i_type(1, 0, 0, 17, core_pkg::OP_IMM);
    rom[19] = b_type(8, 1, 2, 4);
    rom[20] = i_type(2, 0, 0, 17, core_pkg::OP_IMM);
    rom[21] = b_type(8, 1, 2, 7);
    rom[22] = i_type(3, 0, 0, 17, core_pkg::OP_IMM);
    rom[23] = b_type(8, 1, 1, 1);
    rom[24] = b_type(8, 1, 2, 5);
    rom[25] = j_type(8, 18);
    rom[26] = i_type(4, 0, 0, 17, core_pkg::OP_IMM);
    rom[27] = u_type(0, 19, core_pkg::AUIPC);
    // odd offset so bit 0 of the target must drop
    rom[28] = i_type(13, 19, 0, 20, core_pkg::JALR);
    rom[29] = i_type(5, 0, 0, 17, core_pkg::OP_IMM);
    rom[30] = i_type(0, 20, 0, 21, core_pkg::OP_IMM);
    rom[31] = core_pkg::EBREAK_INSTR;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: core stopped retiring after %0d of %0d retires", n_seen, N_EXP);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic ok;
    reset   = 1'b1;
    n_added = 0;
    n_seen  = 0;
    n_pass  = 0;
    n_fail  = 0;
    add_expect("addi_pos", 0, 1, 1'b1, 32'd100);
    add_expect("addi_neg", 1, 2, 1'b1, 32'hffff_fff9);
    add_expect("add", 2, 3, 1'b1, 32'd93);
    add_expect("sub", 3, 4, 1'b1, 32'd107);
    add_expect("and", 4, 5, 1'b1, 32'h0000_0060);
    add_expect("or", 5, 6, 1'b1, 32'hffff_fffd);
    add_expect("xor", 6, 7, 1'b1, 32'hffff_ff9d);
    add_expect("slt", 7, 8, 1'b1, 32'd1);
    add_expect("sltu", 8, 9, 1'b1, 32'd0);
    add_expect("addi_shamt", 9, 10, 1'b1, 32'd3);
    add_expect("sll", 10, 11, 1'b1, 32'hffff_ffc8);
    add_expect("srl", 11, 12, 1'b1, 32'h1fff_ffff);
    add_expect("sra", 12, 13, 1'b1, 32'hffff_ffff);
    add_expect("addi_x0", 13, 0, 1'b1, 32'd55);
    add_expect("add_x0", 14, 14, 1'b1, 32'd100);
    add_expect("lui", 15, 15, 1'b1, 32'h1234_5000);
    add_expect("auipc", 16, 16, 1'b1, addr_of(16) + 32'h1000);
    // branch rd field carries offset bits
    add_expect("beq_taken", 17, 8, 1'b0, 32'd0);
    add_expect("blt_taken", 19, 8, 1'b0, 32'd0);
    add_expect("bgeu_taken", 21, 8, 1'b0, 32'd0);
    add_expect("bne_untaken", 23, 8, 1'b0, 32'd0);
    add_expect("bge_untaken", 24, 8, 1'b0, 32'd0);
    add_expect("jal", 25, 18, 1'b1, addr_of(25) + 32'd4);
    add_expect("auipc_base", 27, 19, 1'b1, addr_of(27));
    add_expect("jalr", 28, 20, 1'b1, addr_of(28) + 32'd4);
    add_expect("link_readback", 30, 21, 1'b1, addr_of(28) + 32'd4);

    repeat (4) @(posedge clock);
    #1 reset = 1'b0;

    @(negedge clock);
    ok = 1'b1;
    compare("reset_state", "pc", core_pkg::RESET_PC, imem_addr, ok);
    compare("reset_state", "retire_valid", 32'd0, {31'b0, retire_valid}, ok);
    compare("reset_state", "halted", 32'd0, {31'b0, halted}, ok);
    report_test("reset_state", ok);

    for (int i = 0; i < N_EXP; i++) begin
      while (!retire_valid) begin
        @(negedge clock);
      end
      check_retire(i);
      n_seen++;
      @(negedge clock);
    end

    ok = 1'b1;
    repeat (10) begin
      assert (!retire_valid) else begin
        $display("halt: retire pulse from pc %h after the last expected retire", retire.pc);
        ok = 1'b0;
      end
      @(negedge clock);
    end
    compare("halt", "halted", 32'd1, {31'b0, halted}, ok);
    compare("halt", "imem_addr", addr_of(31), imem_addr, ok);
    report_test("halt", ok);

    $display("%0d tests passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
core_pkg.sv
reg_file.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
core_top.sv
tb_core.sv

// File: Makefile
SRCS := $(shell cat src.f)

.PHONY: run clean

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

obj_dir/Vtb_core: src.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_core -f src.f

clean:
	rm -rf obj_dir sim.log
